//--- hw/ar_forward.sv
module ar_forward (
    input  logic              S_AXI_ACLK,
    input  logic              arstall,
    input  xbar_pkg::ar_req_t ar_i,
    input  logic              grant_i,
    input  logic              arready_i,
    output xbar_pkg::ar_req_t ar_o,
    output logic              taken_o
);
    import xbar_pkg::*;

    logic    valid_q;
    logic    stall;
    ar_req_t ar_q;

    // output still waiting on the subordinate
    assign stall   = valid_q && !arready_i;
    assign taken_o = grant_i && !stall && ar_i.valid;

    always_ff @(posedge S_AXI_ACLK)
    begin
        if (!arstall || !grant_i)
            valid_q <= 1'b0;
        else if (!stall)
            valid_q <= ar_i.valid;
    end

    always_ff @(posedge S_AXI_ACLK)
    begin
        if (taken_o)
            ar_q <= ar_i;
    end

    always_comb
    begin
        ar_o       = ar_q;
        ar_o.valid = valid_q;
    end

endmodule

//--- hw/axi_read_xbar.sv
module axi_read_xbar (
    input  logic                S_AXI_ACLK,
    input  logic                arstall,
    input  xbar_pkg::ar_req_t   s_ar_i      [xbar_pkg::NUM_MASTERS],
    output xbar_pkg::mst_mask_t s_arready_o,
    output xbar_pkg::r_beat_t   s_r_o       [xbar_pkg::NUM_MASTERS],
    input  xbar_pkg::mst_mask_t s_rready_i,
    output xbar_pkg::ar_req_t   m_ar_o      [xbar_pkg::NUM_SLAVES],
    input  xbar_pkg::slv_mask_t m_arready_i,
    input  xbar_pkg::r_beat_t   m_r_i       [xbar_pkg::NUM_SLAVES],
    output xbar_pkg::slv_mask_t m_rready_o
);
    import xbar_pkg::*;

    slv_mask_t            req       [NUM_MASTERS];
    r_beat_t              dec_r     [NUM_MASTERS];
    mst_mask_t            busy;
    mst_mask_t            ar_taken;
    mst_mask_t            r_last_taken;
    logic [MST_IDX_W-1:0] grant_idx [NUM_SLAVES];
    slv_mask_t            grant;
    slv_mask_t            fwd_taken;
    slv_mask_t            last_done;
    mst_mask_t            arb_req   [NUM_SLAVES];
    ar_req_t              fwd_in    [NUM_SLAVES];

    always_comb
    begin
        ar_taken = '0;
        for (int k = 0; k < NUM_SLAVES; k++)
        begin
            for (int j = 0; j < NUM_MASTERS; j++)
                arb_req[k][j] = req[j][k];
            // only the granted manager may load the AR stage
            fwd_in[k]       = s_ar_i[grant_idx[k]];
            fwd_in[k].valid = req[grant_idx[k]][k];
            if (fwd_taken[k])
                ar_taken[grant_idx[k]] = 1'b1;
        end
        for (int j = 0; j < NUM_MASTERS; j++)
            r_last_taken[j] = busy[j] && s_r_o[j].valid && s_r_o[j].last && s_rready_i[j];
    end

    genvar m, s;

    generate
        for (m = 0; m < NUM_MASTERS; m++)
        begin : g_mst
            read_master_port u_port (
                .S_AXI_ACLK    (S_AXI_ACLK),
                .arstall       (arstall),
                .ar_i          (s_ar_i[m]),
                .rready_i      (s_rready_i[m]),
                .dec_r_taken_i (r_last_taken[m]),
                .ar_taken_i    (ar_taken[m]),
                .arready_o     (s_arready_o[m]),
                .req_o         (req[m]),
                .dec_r_o       (dec_r[m]),
                .busy_o        (busy[m])
            );
        end

        for (s = 0; s < NUM_SLAVES; s++)
        begin : g_slv
            read_arbiter u_arb (
                .S_AXI_ACLK  (S_AXI_ACLK),
                .arstall     (arstall),
                .req_i       (arb_req[s]),
                .last_done_i (last_done[s]),
                .grant_idx_o (grant_idx[s]),
                .grant_o     (grant[s])
            );

            ar_forward u_fwd (
                .S_AXI_ACLK (S_AXI_ACLK),
                .arstall    (arstall),
                .ar_i       (fwd_in[s]),
                .grant_i    (grant[s]),
                .arready_i  (m_arready_i[s]),
                .ar_o       (m_ar_o[s]),
                .taken_o    (fwd_taken[s])
            );
        end
    endgenerate

    r_return_mux u_rmux (
        .m_r_i       (m_r_i),
        .grant_idx_i (grant_idx),
        .grant_i     (grant),
        .s_rready_i  (s_rready_i),
        .dec_r_i     (dec_r),
        .s_r_o       (s_r_o),
        .m_rready_o  (m_rready_o),
        .last_done_o (last_done)
    );

endmodule

//--- hw/r_return_mux.sv
module r_return_mux (
    input  xbar_pkg::r_beat_t              m_r_i       [xbar_pkg::NUM_SLAVES],
    input  logic [xbar_pkg::MST_IDX_W-1:0] grant_idx_i [xbar_pkg::NUM_SLAVES],
    input  xbar_pkg::slv_mask_t            grant_i,
    input  xbar_pkg::mst_mask_t            s_rready_i,
    input  xbar_pkg::r_beat_t              dec_r_i     [xbar_pkg::NUM_MASTERS],
    output xbar_pkg::r_beat_t              s_r_o       [xbar_pkg::NUM_MASTERS],
    output xbar_pkg::slv_mask_t            m_rready_o,
    output xbar_pkg::slv_mask_t            last_done_o
);
    import xbar_pkg::*;

    always_comb
    begin
        // managers nobody owes beats to see their own decode responder
        for (int m = 0; m < NUM_MASTERS; m++)
            s_r_o[m] = dec_r_i[m];

        for (int s = 0; s < NUM_SLAVES; s++)
        begin
            if (grant_i[s])
            begin
                s_r_o[grant_idx_i[s]] = m_r_i[s];
                m_rready_o[s]         = s_rready_i[grant_idx_i[s]];
            end
            else
            begin
                // stray beats from an idle subordinate are drained
                m_rready_o[s] = 1'b1;
            end
            last_done_o[s] = grant_i[s] && m_r_i[s].valid && m_r_i[s].last && m_rready_o[s];
        end
    end

endmodule

//--- hw/read_arbiter.sv
module read_arbiter (
    input  logic                           S_AXI_ACLK,
    input  logic                           arstall,
    input  xbar_pkg::mst_mask_t            req_i,
    input  logic                           last_done_i,
    output logic [xbar_pkg::MST_IDX_W-1:0] grant_idx_o,
    output logic                           grant_o
);
    import xbar_pkg::*;

    logic [MST_IDX_W-1:0] pick_idx;

    // scan from the top so the lowest requester is the one left
    always_comb
    begin
        pick_idx = '0;
        for (int m = NUM_MASTERS - 1; m >= 0; m--)
        begin
            if (req_i[m])
                pick_idx = MST_IDX_W'(m);
        end
    end

    always_ff @(posedge S_AXI_ACLK)
    begin
        if (!arstall)
            grant_o <= 1'b0;
        else if (grant_o)
        begin
            // burst over once its last beat has been handed back
            if (last_done_i)
                grant_o <= 1'b0;
        end
        else if (|req_i)
            grant_o <= 1'b1;
    end

    // index follows the requests only while the subordinate is free
    always_ff @(posedge S_AXI_ACLK)
    begin
        if (!grant_o)
            grant_idx_o <= pick_idx;
    end

endmodule

//--- hw/read_master_port.sv
module read_master_port (
    input  logic                S_AXI_ACLK,
    input  logic                arstall,
    input  xbar_pkg::ar_req_t   ar_i,
    input  logic                rready_i,
    input  logic                dec_r_taken_i,
    input  logic                ar_taken_i,
    output logic                arready_o,
    output xbar_pkg::slv_mask_t req_o,
    output xbar_pkg::r_beat_t   dec_r_o,
    output logic                busy_o
);
    import xbar_pkg::*;

    axi_addr_u        addr;
    logic             mapped;
    logic             dec_accept;
    logic             dec_valid;
    logic             dec_step;
    logic [LEN_W-1:0] beats_left;
    logic [ID_W-1:0]  dec_id;

    assign addr = ar_i.addr;

    // regions past the last subordinate have no target
    assign mapped = (addr.f.region < REGION_W'(NUM_SLAVES));

    always_comb
    begin
        for (int s = 0; s < NUM_SLAVES; s++)
        begin
            req_o[s] = ar_i.valid && !busy_o && (addr.f.region == REGION_W'(s));
        end
    end

    // unmapped requests are swallowed here
    assign dec_accept = ar_i.valid && !busy_o && !mapped;
    assign arready_o  = dec_accept || ar_taken_i;
    assign dec_step   = dec_valid && rready_i;

    always_ff @(posedge S_AXI_ACLK)
    begin
        if (!arstall)
        begin
            busy_o    <= 1'b0;
            dec_valid <= 1'b0;
        end
        else
        begin
            // one burst in flight, held until its last beat is gone
            if (ar_i.valid && arready_o)
                busy_o <= 1'b1;
            else if (dec_r_taken_i)
                busy_o <= 1'b0;

            if (dec_accept)
                dec_valid <= 1'b1;
            else if (dec_step && beats_left == '0)
                dec_valid <= 1'b0;
        end
    end

    always_ff @(posedge S_AXI_ACLK)
    begin
        if (dec_accept)
        begin
            beats_left <= ar_i.len;
            dec_id     <= ar_i.id;
        end
        else if (dec_step && beats_left != '0)
            beats_left <= beats_left - 1'b1;
    end

    always_comb
    begin
        dec_r_o.valid = dec_valid;
        dec_r_o.id    = dec_id;
        dec_r_o.data  = '0;
        dec_r_o.resp  = RESP_DECERR;
        dec_r_o.last  = (beats_left == '0);
    end

endmodule

//--- hw/xbar_pkg.sv
package xbar_pkg;

    localparam int NUM_MASTERS = 2;
    localparam int NUM_SLAVES  = 2;
    localparam int MST_IDX_W   = 1;

    localparam int ADDR_W   = 32;
    localparam int DATA_W   = 32;
    localparam int ID_W     = 4;
    localparam int LEN_W    = 8;
    localparam int REGION_W = 4;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    // interconnect error, nobody lives at that address
    localparam logic [1:0] RESP_DECERR = 2'b11;

    // top nibble selects the subordinate
    typedef struct packed {
        logic [REGION_W-1:0]        region;
        logic [ADDR_W-REGION_W-1:0] offset;
    } addr_fields_t;

    typedef union packed {
        logic [ADDR_W-1:0] raw;
        addr_fields_t      f;
    } axi_addr_u;

    typedef struct packed {
        logic             valid;
        logic [ID_W-1:0]  id;
        axi_addr_u        addr;
        logic [LEN_W-1:0] len;
    } ar_req_t;

    typedef struct packed {
        logic              valid;
        logic [ID_W-1:0]   id;
        logic [DATA_W-1:0] data;
        logic [1:0]        resp;
        logic              last;
    } r_beat_t;

    typedef logic [NUM_MASTERS-1:0] mst_mask_t;
    typedef logic [NUM_SLAVES-1:0]  slv_mask_t;

endpackage

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the crossbar testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --top-module tb_top -f vlog.f -o sim_tb > build.log 2>&1 \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || { echo "build or simulation failed, see build.log and sim.log"; exit 1; }

grep -q "Test FAILED" sim.log \
    && { echo "simulation FAILED, see sim.log"; exit 1; } \
    || { echo "simulation passed"; exit 0; }

//--- testbench/read_vectors.txt
// test manager id address len resp together (all hex)
// together=1 issues the line in the same cycle as the next one
01 0 1 00000100 03 0 0
02 0 2 10000200 00 0 0
03 1 3 00000040 07 0 0
04 1 4 1000ff00 02 0 0
05 0 5 30000000 03 3 0
06 1 6 f0001000 00 3 0
07 0 7 00000800 05 0 1
08 1 8 00000c00 05 0 0
09 0 9 00002000 03 0 1
0a 1 a 10003000 04 0 0
0b 0 b 10000ffc 07 0 0
0c 1 c 20000000 01 3 1
0d 0 d 00000010 02 0 0
0e 0 e 0ffffff8 03 0 0
0f 1 f 10000400 0f 0 0

//--- testbench/tb_checker.sv
module tb_checker (
    input  logic                S_AXI_ACLK,
    input  logic                arstall,
    input  xbar_pkg::ar_req_t   s_ar_i      [xbar_pkg::NUM_MASTERS],
    input  xbar_pkg::mst_mask_t s_arready_i,
    input  xbar_pkg::r_beat_t   s_r_i       [xbar_pkg::NUM_MASTERS],
    input  xbar_pkg::mst_mask_t s_rready_i,
    input  xbar_pkg::ar_req_t   m_ar_i      [xbar_pkg::NUM_SLAVES],
    input  xbar_pkg::slv_mask_t m_arready_i,
    input  logic [7:0]          test_i      [xbar_pkg::NUM_MASTERS],
    input  logic [1:0]          resp_i      [xbar_pkg::NUM_MASTERS],
    output int                  tests_done_o,
    output int                  tests_failed_o,
    output int                  errors_o,
    output int                  ar_expected_o,
    output int                  ar_seen_o
);
    timeunit 1ns;
    timeprecision 100ps;

    import xbar_pkg::*;

    typedef struct packed {
        logic [7:0]       test;
        logic [ID_W-1:0]  id;
        logic [31:0]      addr;
        logic [LEN_W-1:0] len;
        logic [1:0]       resp;
    } exp_t;

    exp_t cur    [NUM_MASTERS];
    logic active [NUM_MASTERS];
    int   beat   [NUM_MASTERS];
    int   bad    [NUM_MASTERS];

    // beat address with its region replaced by subordinate number plus 1
    function automatic logic [31:0] beat_data(input logic [31:0] addr, input int i);
        axi_addr_u a;
        a.raw      = addr + 32'(4 * i);
        a.f.region = addr[31:28] + 4'd1;
        return a.raw;
    endfunction

    task automatic mismatch(input int m, input string what, input logic [31:0] got,
                            input logic [31:0] exp);
        $display("MISMATCH at %0t: test %0d manager %0d beat %0d %s got %h expected %h",
                 $time, cur[m].test, m, beat[m], what, got, exp);
        bad[m]++;
        errors_o++;
    endtask

    task automatic check_beat(input int m);
        int          o;
        logic [31:0] d;
        o = 1 - m;
        d = (cur[m].resp == RESP_DECERR) ? 32'h0 : beat_data(cur[m].addr, beat[m]);
        if (s_r_i[m].id != cur[m].id)
            mismatch(m, "id", 32'(s_r_i[m].id), 32'(cur[m].id));
        if (s_r_i[m].resp != cur[m].resp)
            mismatch(m, "resp", 32'(s_r_i[m].resp), 32'(cur[m].resp));
        if (s_r_i[m].data != d)
            mismatch(m, "data", s_r_i[m].data, d);
        if (s_r_i[m].last != (beat[m] == int'(cur[m].len)))
            mismatch(m, "last", 32'(s_r_i[m].last), 32'(beat[m] == int'(cur[m].len)));
        // one burst per subordinate and the lower manager goes first
        if (cur[m].resp != RESP_DECERR
            && ((active[o] && beat[o] > 0 && cur[o].resp != RESP_DECERR
                 && cur[o].addr[31:28] == cur[m].addr[31:28])
                || (o < m && s_ar_i[o].valid
                    && s_ar_i[o].addr.raw[31:28] == cur[m].addr[31:28])))
        begin
            $display("error at %0t: test %0d beats out of order with another burst",
                     $time, cur[m].test);
            bad[m]++;
            errors_o++;
        end
        if (beat[m] == int'(cur[m].len))
        begin
            $display("test %0d manager %0d: %s", cur[m].test, m,
                     (bad[m] == 0) ? "pass" : "fail");
            if (bad[m] != 0)
                tests_failed_o++;
            tests_done_o++;
            active[m] = 1'b0;
        end
        else
            beat[m]++;
    endtask

    initial
    begin
        tests_done_o   = 0;
        tests_failed_o = 0;
        errors_o       = 0;
        ar_expected_o  = 0;
        ar_seen_o      = 0;
        for (int m = 0; m < NUM_MASTERS; m++)
            active[m] = 1'b0;
    end

    // sample at the falling edge, where everything is settled
    always @(negedge S_AXI_ACLK)
    begin
        if (arstall)
        begin
            for (int m = 0; m < NUM_MASTERS; m++)
            begin
                if (s_r_i[m].valid && !active[m])
                begin
                    $display("error at %0t: R valid on idle manager %0d", $time, m);
                    errors_o++;
                end
                else if (s_r_i[m].valid && s_rready_i[m])
                    check_beat(m);
                if (s_ar_i[m].valid && s_arready_i[m])
                begin
                    cur[m]    = '{test_i[m], s_ar_i[m].id, s_ar_i[m].addr.raw,
                                  s_ar_i[m].len, resp_i[m]};
                    active[m] = 1'b1;
                    beat[m]   = 0;
                    bad[m]    = 0;
                    if (resp_i[m] != RESP_DECERR)
                        ar_expected_o++;
                end
            end
            for (int s = 0; s < NUM_SLAVES; s++)
            begin
                if (m_ar_i[s].valid && m_arready_i[s])
                    ar_seen_o++;
            end
        end
    end

endmodule

//--- testbench/tb_top.sv
module tb_top;
    timeunit 1ns;
    timeprecision 100ps;

    import xbar_pkg::*;

    localparam int MAX_VEC = 64;

    logic       S_AXI_ACLK;
    logic       arstall;
    ar_req_t    s_ar_i      [NUM_MASTERS];
    mst_mask_t  s_arready_o;
    r_beat_t    s_r_o       [NUM_MASTERS];
    mst_mask_t  s_rready_i;
    ar_req_t    m_ar_o      [NUM_SLAVES];
    slv_mask_t  m_arready_i;
    r_beat_t    m_r_i       [NUM_SLAVES];
    slv_mask_t  m_rready_o;
    logic [7:0] cur_test    [NUM_MASTERS];
    logic [1:0] cur_resp    [NUM_MASTERS];

    int tests_done;
    int tests_failed;
    int errors;
    int ar_expected;
    int ar_seen;

    int v_test [MAX_VEC];
    int v_mgr  [MAX_VEC];
    int v_id   [MAX_VEC];
    int v_addr [MAX_VEC];
    int v_len  [MAX_VEC];
    int v_resp [MAX_VEC];
    int v_pair [MAX_VEC];
    int n_vec;
    int limit;
    int cycles;
    int issued;

    axi_read_xbar u_dut (
        .S_AXI_ACLK  (S_AXI_ACLK),
        .arstall     (arstall),
        .s_ar_i      (s_ar_i),
        .s_arready_o (s_arready_o),
        .s_r_o       (s_r_o),
        .s_rready_i  (s_rready_i),
        .m_ar_o      (m_ar_o),
        .m_arready_i (m_arready_i),
        .m_r_i       (m_r_i),
        .m_rready_o  (m_rready_o)
    );

    tb_checker u_chk (
        .S_AXI_ACLK     (S_AXI_ACLK),
        .arstall        (arstall),
        .s_ar_i         (s_ar_i),
        .s_arready_i    (s_arready_o),
        .s_r_i          (s_r_o),
        .s_rready_i     (s_rready_i),
        .m_ar_i         (m_ar_o),
        .m_arready_i    (m_arready_i),
        .test_i         (cur_test),
        .resp_i         (cur_resp),
        .tests_done_o   (tests_done),
        .tests_failed_o (tests_failed),
        .errors_o       (errors),
        .ar_expected_o  (ar_expected),
        .ar_seen_o      (ar_seen)
    );

    initial
    begin
        S_AXI_ACLK = 1'b0;
        forever
            #10 S_AXI_ACLK = ~S_AXI_ACLK;
    end

    always @(posedge S_AXI_ACLK)
    begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit)
        begin
            $display("timeout: run exceeded %0d cycles", limit);
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic read_vectors();
        int    fd;
        string line;
        int    t, m, i, a, l, r, p;
        fd    = $fopen("testbench/read_vectors.txt", "r");
        n_vec = 0;
        if (fd == 0)
            $display("error: cannot open testbench/read_vectors.txt");
        else
        begin
            while (!$feof(fd) && n_vec < MAX_VEC)
            begin
                void'($fgets(line, fd));
                // comment and blank lines match nothing
                if ($sscanf(line, "%h %h %h %h %h %h %h", t, m, i, a, l, r, p) == 7)
                begin
                    v_test[n_vec] = t;
                    v_mgr[n_vec]  = m;
                    v_id[n_vec]   = i;
                    v_addr[n_vec] = a;
                    v_len[n_vec]  = l;
                    v_resp[n_vec] = r;
                    v_pair[n_vec] = p;
                    n_vec++;
                end
            end
            $fclose(fd);
        end
    endtask

    // subordinate model, one per port
    task automatic subordinate(input int s);
        ar_req_t   req;
        axi_addr_u a;
        int        d;
        logic      acc;
        forever
        begin
            @(negedge S_AXI_ACLK);
            if (arstall && m_ar_o[s].valid)
            begin
                req = m_ar_o[s];
                d   = int'($urandom_range(3, 0));
                @(posedge S_AXI_ACLK);
                #2;
                repeat (d)
                begin
                    @(posedge S_AXI_ACLK);
                    #2;
                end
                m_arready_i[s] = 1'b1;
                @(posedge S_AXI_ACLK);
                #2;
                m_arready_i[s] = 1'b0;
                for (int i = 0; i <= int'(req.len); i++)
                begin
                    a.raw      = req.addr.raw + 32'(4 * i);
                    a.f.region = 4'(s + 1);
                    m_r_i[s]   = '{1'b1, req.id, a.raw, RESP_OKAY, (i == int'(req.len))};
                    do
                    begin
                        @(negedge S_AXI_ACLK);
                        acc = m_rready_o[s];
                        @(posedge S_AXI_ACLK);
                        #2;
                    end
                    while (!acc);
                end
                m_r_i[s] = '0;
            end
        end
    endtask

    task automatic issue(input int k);
        int   m;
        logic acc;
        m                 = v_mgr[k];
        cur_test[m]       = 8'(v_test[k]);
        cur_resp[m]       = 2'(v_resp[k]);
        s_ar_i[m].id      = ID_W'(v_id[k]);
        s_ar_i[m].addr    = v_addr[k];
        s_ar_i[m].len     = LEN_W'(v_len[k]);
        s_ar_i[m].valid   = 1'b1;
        do
        begin
            @(negedge S_AXI_ACLK);
            acc = s_arready_o[m];
            @(posedge S_AXI_ACLK);
            #2;
        end
        while (!acc);
        s_ar_i[m].valid = 1'b0;
    endtask

    // random back-pressure on the manager R channels
    initial
    begin
        @(posedge arstall);
        forever
        begin
            @(posedge S_AXI_ACLK);
            #2;
            for (int m = 0; m < NUM_MASTERS; m++)
                s_rready_i[m] = ($urandom_range(3, 0) != 0);
        end
    end

    initial
    begin
        void'($urandom(32'hd65f186d));
        cycles = 0;
        limit  = 0;
        issued = 0;
        arstall     = 1'b0;
        s_rready_i  = '1;
        m_arready_i = '0;
        for (int m = 0; m < NUM_MASTERS; m++)
        begin
            s_ar_i[m]   = '0;
            cur_test[m] = '0;
            cur_resp[m] = '0;
        end
        for (int s = 0; s < NUM_SLAVES; s++)
            m_r_i[s] = '0;
        read_vectors();
        limit = 40 * n_vec + 100;
        fork
            subordinate(0);
            subordinate(1);
        join_none
        repeat (2) @(posedge S_AXI_ACLK);
        #2;
        arstall = 1'b1;
        // idle stretch, any beat here is flagged by the checker
        repeat (5) @(posedge S_AXI_ACLK);
        #2;
        for (int k = 0; k < n_vec; k++)
        begin
            if (v_pair[k] != 0 && k + 1 < n_vec)
            begin
                fork
                    issue(k);
                    issue(k + 1);
                join
                issued += 2;
                k++;
            end
            else
            begin
                issue(k);
                issued++;
            end
            while (tests_done < issued)
            begin
                @(posedge S_AXI_ACLK);
                #2;
            end
        end
        repeat (3) @(posedge S_AXI_ACLK);
        if (ar_seen != ar_expected)
            $display("error: %0d AR transfers reached subordinates, %0d expected",
                     ar_seen, ar_expected);
        $display("tests %0d, failed %0d, errors %0d", tests_done, tests_failed, errors);
        if (errors == 0 && tests_failed == 0 && tests_done == n_vec && n_vec > 0
            && ar_seen == ar_expected)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

//--- vlog.f
hw/xbar_pkg.sv
hw/read_master_port.sv
hw/read_arbiter.sv
hw/ar_forward.sv
hw/r_return_mux.sv
hw/axi_read_xbar.sv
testbench/tb_checker.sv
testbench/tb_top.sv
